// File: design/corr_macros.svh
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// ----------------------------------------------------------------------
// Correlator sizing
// ----------------------------------------------------------------------

// Antenna lanes on the sample bus
`define CORR_ANTENNAS 24

// Fixed antenna pairs, one slot each per sample
`define CORR_SLOTS 12

// Width of each cos/sin count, wraps modulo 2**width
`define CORR_ACCUM 12

// Readout address to readout data, in clk_x cycles
`define CORR_RD_LAT 2

`endif

// File: design/corr_pkg.sv
`include "corr_macros.svh"

package corr_pkg;

   // ----------------------------------------------------------------------
   // Index types
   // ----------------------------------------------------------------------

   // Slot counter, 12 slots used out of 16
   typedef logic [3:0] slot_t;

   // Antenna lane index
   typedef logic [4:0] ant_t;

   // One correlated pair, a on the real side and b on both sides
   typedef struct packed {
      ant_t a;
      ant_t b;
   } pair_t;

   // Stored visibility, sin in the upper half
   typedef struct packed {
      logic [`CORR_ACCUM-1:0] sin;
      logic [`CORR_ACCUM-1:0] cos;
   } vis_t;

   // ----------------------------------------------------------------------
   // Pair table
   // ----------------------------------------------------------------------

   // Slot k pairs antenna k with antenna k+12
   parameter pair_t corr_pairs [0:`CORR_SLOTS-1] = '{
      '{a: 5'd0,  b: 5'd12},
      '{a: 5'd1,  b: 5'd13},
      '{a: 5'd2,  b: 5'd14},
      '{a: 5'd3,  b: 5'd15},
      '{a: 5'd4,  b: 5'd16},
      '{a: 5'd5,  b: 5'd17},
      '{a: 5'd6,  b: 5'd18},
      '{a: 5'd7,  b: 5'd19},
      '{a: 5'd8,  b: 5'd20},
      '{a: 5'd9,  b: 5'd21},
      '{a: 5'd10, b: 5'd22},
      '{a: 5'd11, b: 5'd23}
   };

endpackage

// File: design/corr_sequencer.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_sequencer import corr_pkg::*; (
   input  logic                      clk_x,
   input  logic                      rst,
   input  logic                      samp_req,
   input  logic [`CORR_ANTENNAS-1:0] samp_re,
   input  logic [`CORR_ANTENNAS-1:0] samp_im,
   input  logic                      swap_req,
   input  logic                      rd_busy,
   output logic                      samp_ack,
   output logic                      swap_ack,
   output logic [`CORR_ANTENNAS-1:0] lat_re,
   output logic [`CORR_ANTENNAS-1:0] lat_im,
   output slot_t                     slot,
   output logic                      slot_go,
   output logic                      clr,
   output logic                      bank
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RUN,
      S_WAIT,
      S_ACK
   } state_t;

   localparam slot_t SLOT_LAST = slot_t'(`CORR_SLOTS - 1);
   // Last slot leaves the add stage two cycles on, RAM takes it the cycle after
   localparam logic [1:0] WAIT_LAST = 2'd2;

   state_t                  state;
   logic [1:0]              wait_cnt;
   logic [`CORR_SLOTS-1:0]  clr_mask;

   // Old flag value goes out with the slot, bit drops at the same edge
   assign clr = clr_mask[slot];

   // ----------------------------------------------------------------------
   // Control FSM, bank and clear flags
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state    <= S_IDLE;
         samp_ack <= 1'b0;
         swap_ack <= 1'b0;
         slot     <= '0;
         slot_go  <= 1'b0;
         wait_cnt <= '0;
         bank     <= 1'b0;
         clr_mask <= '1;
      end else begin
         // First touch of a slot consumes its flag
         if (slot_go)
            clr_mask[slot] <= 1'b0;

         // Swap ack follows its req down
         if (swap_ack && !swap_req)
            swap_ack <= 1'b0;

         case (state)
            S_IDLE: begin
               if (samp_req && !samp_ack) begin
                  state   <= S_RUN;
                  slot    <= '0;
                  slot_go <= 1'b1;
               end else if (swap_req && !swap_ack && !rd_busy) begin
                  // Pipeline is empty here, safe to flip
                  bank     <= ~bank;
                  clr_mask <= '1;
                  swap_ack <= 1'b1;
               end
            end
            S_RUN: begin
               if (slot == SLOT_LAST) begin
                  slot_go  <= 1'b0;
                  wait_cnt <= '0;
                  state    <= S_WAIT;
               end else begin
                  slot <= slot + slot_t'(1);
               end
            end
            S_WAIT: begin
               // Drain lookup, read and add stages
               if (wait_cnt == WAIT_LAST) begin
                  samp_ack <= 1'b1;
                  state    <= S_ACK;
               end else begin
                  wait_cnt <= wait_cnt + 2'd1;
               end
            end
            default: begin
               if (!samp_req) begin
                  samp_ack <= 1'b0;
                  state    <= S_IDLE;
               end
            end
         endcase
      end
   end

   // Sample capture as the request is taken
   always_ff @(posedge clk_x) begin
      if (state == S_IDLE && samp_req && !samp_ack) begin
         lat_re <= samp_re;
         lat_im <= samp_im;
      end
   end

   a_slot_range: assert property (@(posedge clk_x) disable iff (rst)
      slot_go |-> (slot < slot_t'(`CORR_SLOTS)));

endmodule

// File: design/corr_pair_select.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_pair_select import corr_pkg::*; (
   input  slot_t                     slot,
   input  logic [`CORR_ANTENNAS-1:0] lat_re,
   input  logic [`CORR_ANTENNAS-1:0] lat_im,
   output logic                      ar,
   output logic                      br,
   output logic                      bi
);

   pair_t pair;

   // ----------------------------------------------------------------------
   // Table lookup and lane pick
   // ----------------------------------------------------------------------

   // Slot picks its pair from the fixed table
   assign pair = corr_pairs[slot];

   // Real of a against real and imag of b
   assign ar = lat_re[pair.a];
   assign br = lat_re[pair.b];
   assign bi = lat_im[pair.b];

   // Table entries must land on real lanes
   always_comb begin
      if (slot < slot_t'(`CORR_SLOTS)) begin
         a_ant_range: assert ((pair.a < ant_t'(`CORR_ANTENNAS)) &&
                              (pair.b < ant_t'(`CORR_ANTENNAS)))
            else $error("pair table index past the antenna lanes");
      end
   end

endmodule

// File: design/corr_accumulate.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_accumulate import corr_pkg::*; (
   input  logic  clk_x,
   input  logic  rst,
   input  logic  slot_go,
   input  slot_t slot,
   input  logic  clr,
   input  logic  bank,
   input  logic  ar,
   input  logic  br,
   input  logic  bi,
   input  vis_t  rd_vis,
   output logic  wr_en,
   output logic  wr_bank,
   output slot_t wr_slot,
   output vis_t  wr_data
);

   logic  go_d;
   logic  clr_d;
   logic  bank_d;
   slot_t slot_d;
   logic  cos_d;
   logic  sin_d;
   vis_t  base;

   // ----------------------------------------------------------------------
   // Stage one, wait out the RAM read
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst)
         go_d <= 1'b0;
      else
         go_d <= slot_go;
   end

   always_ff @(posedge clk_x) begin
      slot_d <= slot;
      clr_d  <= clr;
      bank_d <= bank;
      // One-bit correlation, agreement counts up
      cos_d  <= ~(ar ^ br);
      sin_d  <= ~(ar ^ bi);
   end

   // ----------------------------------------------------------------------
   // Stage two, add and register the write
   // ----------------------------------------------------------------------

   // Zero in place of the stored count after a swap
   assign base = clr_d ? '0 : rd_vis;

   always_ff @(posedge clk_x) begin
      if (rst)
         wr_en <= 1'b0;
      else
         wr_en <= go_d;
   end

   always_ff @(posedge clk_x) begin
      wr_bank     <= bank_d;
      wr_slot     <= slot_d;
      // Counts wrap on overflow
      wr_data.cos <= base.cos + {{(`CORR_ACCUM-1){1'b0}}, cos_d};
      wr_data.sin <= base.sin + {{(`CORR_ACCUM-1){1'b0}}, sin_d};
   end

endmodule

// File: design/corr_accum_ram.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_accum_ram import corr_pkg::*; (
   input  logic  clk_x,
   input  logic  acc_bank,
   input  slot_t acc_slot,
   input  logic  wr_en,
   input  logic  wr_bank,
   input  slot_t wr_slot,
   input  vis_t  wr_data,
   input  logic  rd_bank,
   input  slot_t rd_slot,
   input  logic  rd_busy,
   output vis_t  acc_vis,
   output vis_t  rd_vis
);

   // Two banks of one entry per pair
   vis_t mem [0:1][0:`CORR_SLOTS-1];

   // Power-up contents are zero, so an untouched bank reads back clean
   initial begin
      for (int b = 0; b < 2; b++) begin
         for (int s = 0; s < `CORR_SLOTS; s++) begin
            mem[b][s] = '0;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Write port, fed by the add stage
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (wr_en)
         mem[wr_bank][wr_slot] <= wr_data;
   end

   // ----------------------------------------------------------------------
   // Read ports, both registered
   // ----------------------------------------------------------------------

   // Accumulate side, active bank
   always_ff @(posedge clk_x) begin
      acc_vis <= mem[acc_bank][acc_slot];
   end

   // Readout side, finished bank
   always_ff @(posedge clk_x) begin
      rd_vis <= mem[rd_bank][rd_slot];
   end

   // Readout bank must stay frozen while the bus is in a transfer
   a_no_rd_clash: assert property (@(posedge clk_x)
      (wr_en && rd_busy) |-> (wr_bank != rd_bank));

endmodule

// File: design/corr_readout.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_readout import corr_pkg::*; (
   input  logic  clk_x,
   input  logic  rst,
   input  logic  bus_req,
   input  slot_t bus_addr,
   input  logic  bank,
   input  vis_t  ram_vis,
   output logic  bus_ack,
   output vis_t  bus_data,
   output slot_t rd_slot,
   output logic  rd_bank,
   output logic  rd_busy
);

   typedef enum logic [1:0] {
      R_IDLE,
      R_WAIT,
      R_ACK
   } state_t;

   localparam int CNT_W = $clog2(`CORR_RD_LAT + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CORR_RD_LAT);

   state_t           state;
   logic [CNT_W-1:0] cnt;
   logic             take;

   // Bus only ever sees the bank the sequencer is not filling
   assign rd_bank = ~bank;

   // Busy as soon as a request shows, keeps a swap from slipping in
   assign rd_busy = (state != R_IDLE) || bus_req;

   assign take = (state == R_IDLE) && bus_req && !bus_ack;

   // ----------------------------------------------------------------------
   // Bus FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state   <= R_IDLE;
         cnt     <= '0;
         bus_ack <= 1'b0;
      end else begin
         case (state)
            R_IDLE: begin
               if (take) begin
                  cnt   <= '0;
                  state <= R_WAIT;
               end
            end
            R_WAIT: begin
               // RAM output has settled by now
               if (cnt == CNT_LAST) begin
                  bus_ack <= 1'b1;
                  state   <= R_ACK;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            default: begin
               if (!bus_req) begin
                  bus_ack <= 1'b0;
                  state   <= R_IDLE;
               end
            end
         endcase
      end
   end

   // Address in, data out, both held for the transfer
   always_ff @(posedge clk_x) begin
      if (take)
         rd_slot <= bus_addr;
      if (state == R_WAIT && cnt == CNT_LAST)
         bus_data <= ram_vis;
   end

   a_addr_range: assert property (@(posedge clk_x) disable iff (rst)
      bus_req |-> (bus_addr < slot_t'(`CORR_SLOTS)));

endmodule

// File: design/corr_block_top.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_block_top import corr_pkg::*; (
   input  logic                      clk_x,
   input  logic                      rst,
   // Sample channel
   input  logic                      samp_req,
   input  logic [`CORR_ANTENNAS-1:0] samp_re,
   input  logic [`CORR_ANTENNAS-1:0] samp_im,
   output logic                      samp_ack,
   // Swap channel
   input  logic                      swap_req,
   output logic                      swap_ack,
   // Readout channel
   input  logic                      bus_req,
   input  slot_t                     bus_addr,
   output logic                      bus_ack,
   output vis_t                      bus_data
);

   logic [`CORR_ANTENNAS-1:0] lat_re;
   logic [`CORR_ANTENNAS-1:0] lat_im;
   slot_t                     slot;
   logic                      slot_go;
   logic                      clr;
   logic                      bank;
   logic                      ar;
   logic                      br;
   logic                      bi;
   vis_t                      acc_vis;
   logic                      wr_en;
   logic                      wr_bank;
   slot_t                     wr_slot;
   vis_t                      wr_data;
   slot_t                     rd_slot;
   logic                      rd_bank;
   logic                      rd_busy;
   vis_t                      bus_vis;

   // ----------------------------------------------------------------------
   // Control
   // ----------------------------------------------------------------------
   corr_sequencer u_seq (
      .clk_x(clk_x), .rst(rst),
      .samp_req(samp_req), .samp_re(samp_re), .samp_im(samp_im),
      .swap_req(swap_req), .rd_busy(rd_busy),
      .samp_ack(samp_ack), .swap_ack(swap_ack),
      .lat_re(lat_re), .lat_im(lat_im),
      .slot(slot), .slot_go(slot_go), .clr(clr), .bank(bank)
   );

   // ----------------------------------------------------------------------
   // Datapath, lookup then read then add
   // ----------------------------------------------------------------------
   corr_pair_select u_sel (
      .slot(slot), .lat_re(lat_re), .lat_im(lat_im),
      .ar(ar), .br(br), .bi(bi)
   );

   corr_accumulate u_acc (
      .clk_x(clk_x), .rst(rst),
      .slot_go(slot_go), .slot(slot), .clr(clr), .bank(bank),
      .ar(ar), .br(br), .bi(bi), .rd_vis(acc_vis),
      .wr_en(wr_en), .wr_bank(wr_bank), .wr_slot(wr_slot), .wr_data(wr_data)
   );

   corr_accum_ram u_ram (
      .clk_x(clk_x),
      .acc_bank(bank), .acc_slot(slot),
      .wr_en(wr_en), .wr_bank(wr_bank), .wr_slot(wr_slot), .wr_data(wr_data),
      .rd_bank(rd_bank), .rd_slot(rd_slot), .rd_busy(rd_busy),
      .acc_vis(acc_vis), .rd_vis(bus_vis)
   );

   // Bus side
   corr_readout u_rd (
      .clk_x(clk_x), .rst(rst),
      .bus_req(bus_req), .bus_addr(bus_addr), .bank(bank), .ram_vis(bus_vis),
      .bus_ack(bus_ack), .bus_data(bus_data),
      .rd_slot(rd_slot), .rd_bank(rd_bank), .rd_busy(rd_busy)
   );

endmodule

// File: testbench/corr_tb.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_tb import corr_pkg::*;;

   // ----------------------------------------------------------------------
   // Run constants
   // ----------------------------------------------------------------------
   localparam int CLK_HALF  = 20;
   localparam int ACC_MOD   = 1 << `CORR_ACCUM;
   localparam int ACK_LIMIT = 40;
   // Twelve slot cycles and three to drain the pipeline
   localparam int SAMP_LAT  = `CORR_SLOTS + 3;
   // Read latency plus the capture cycle
   localparam int RD_LAT    = `CORR_RD_LAT + 1;
   localparam int BATCH1    = 200;
   localparam int BATCH2    = 50;
   // Samples, readouts and swaps over the whole run
   localparam int N_SAMPLES = 1 + BATCH1 + BATCH2 + 1;
   localparam int N_READS   = 4 * `CORR_SLOTS + 1;
   localparam int N_SWAPS   = 4;
   localparam int WATCHDOG_NS = (N_SAMPLES + N_READS + N_SWAPS) * 40 * 40 + 10000;

   logic                      clk_x;
   logic                      rst;
   logic                      samp_req;
   logic [`CORR_ANTENNAS-1:0] samp_re;
   logic [`CORR_ANTENNAS-1:0] samp_im;
   logic                      samp_ack;
   logic                      swap_req;
   logic                      swap_ack;
   logic                      bus_req;
   slot_t                     bus_addr;
   logic                      bus_ack;
   vis_t                      bus_data;

   // Model state, two banks plus the clear flags
   vis_t   exp_vis [0:1][0:`CORR_SLOTS-1];
   logic   exp_clr [0:`CORR_SLOTS-1];
   logic   exp_bank;
   vis_t   exp_q[$];
   int     addr_q[$];

   integer seed;
   int     errors;
   int     checks;
   logic   ack_prev;

   corr_block_top DUT (
      .clk_x(clk_x), .rst(rst),
      .samp_req(samp_req), .samp_re(samp_re), .samp_im(samp_im), .samp_ack(samp_ack),
      .swap_req(swap_req), .swap_ack(swap_ack),
      .bus_req(bus_req), .bus_addr(bus_addr), .bus_ack(bus_ack), .bus_data(bus_data)
   );

   initial begin
      clk_x = 1'b0;
      forever #(CLK_HALF) clk_x = ~clk_x;
   end

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------

   // One pair, one sample: agreement counts up, first touch starts at zero
   function automatic vis_t pair_update(input vis_t prev, input logic first,
                                        input logic [`CORR_ANTENNAS-1:0] re,
                                        input logic [`CORR_ANTENNAS-1:0] im,
                                        input int k);
      pair_t p;
      int    c;
      int    s;
      vis_t  nv;
      p = corr_pairs[k];
      c = first ? 0 : int'(prev.cos);
      s = first ? 0 : int'(prev.sin);
      if (re[p.a] == re[p.b])
         c = c + 1;
      // Real of a against imag of b
      if (re[p.a] == im[p.b])
         s = s + 1;
      c = c % ACC_MOD;
      s = s % ACC_MOD;
      nv.cos = c[`CORR_ACCUM-1:0];
      nv.sin = s[`CORR_ACCUM-1:0];
      return nv;
   endfunction

   task automatic model_sample(input logic [`CORR_ANTENNAS-1:0] re,
                               input logic [`CORR_ANTENNAS-1:0] im);
      int act;
      act = exp_bank ? 1 : 0;
      for (int k = 0; k < `CORR_SLOTS; k++) begin
         exp_vis[act][k] = pair_update(exp_vis[act][k], exp_clr[k], re, im, k);
         exp_clr[k] = 1'b0;
      end
   endtask

   // ----------------------------------------------------------------------
   // Four-phase transactions, entered and left 2 ns after a rising edge
   // ----------------------------------------------------------------------
   task automatic send_sample(input logic [`CORR_ANTENNAS-1:0] re,
                              input logic [`CORR_ANTENNAS-1:0] im, output int lat);
      samp_re  = re;
      samp_im  = im;
      samp_req = 1'b1;
      lat = 0;
      @(posedge clk_x);
      #2;
      // Edge count from the first edge that sees req
      while (!samp_ack && lat < ACK_LIMIT) begin
         @(posedge clk_x);
         #2;
         lat++;
      end
      if (!samp_ack) begin
         $display("Sample channel: samp_ack never rose within %0d cycles", ACK_LIMIT);
         errors++;
      end
      samp_req = 1'b0;
      while (samp_ack) begin
         @(posedge clk_x);
         #2;
      end
   endtask

   task automatic random_sample(output int lat);
      logic [31:0] r1;
      logic [31:0] r2;
      r1 = $random(seed);
      r2 = $random(seed);
      send_sample(r1[`CORR_ANTENNAS-1:0], r2[`CORR_ANTENNAS-1:0], lat);
      model_sample(r1[`CORR_ANTENNAS-1:0], r2[`CORR_ANTENNAS-1:0]);
   endtask

   task automatic do_swap();
      int waited;
      swap_req = 1'b1;
      waited = 0;
      @(posedge clk_x);
      #2;
      while (!swap_ack && waited < ACK_LIMIT) begin
         @(posedge clk_x);
         #2;
         waited++;
      end
      if (!swap_ack) begin
         $display("Swap channel: swap_ack never rose within %0d cycles", ACK_LIMIT);
         errors++;
      end
      swap_req = 1'b0;
      while (swap_ack) begin
         @(posedge clk_x);
         #2;
      end
      // Banks trade places, every pair restarts
      exp_bank = ~exp_bank;
      for (int k = 0; k < `CORR_SLOTS; k++)
         exp_clr[k] = 1'b1;
   endtask

   task automatic bus_read(input int k, output int lat);
      // Expected value from the finished bank
      exp_q.push_back(exp_vis[exp_bank ? 0 : 1][k]);
      addr_q.push_back(k);
      bus_addr = slot_t'(k);
      bus_req  = 1'b1;
      lat = 0;
      @(posedge clk_x);
      #2;
      while (!bus_ack && lat < ACK_LIMIT) begin
         @(posedge clk_x);
         #2;
         lat++;
      end
      if (!bus_ack) begin
         $display("Readout channel: bus_ack never rose for slot %0d", k);
         errors++;
         void'(exp_q.pop_front());
         void'(addr_q.pop_front());
      end
      bus_req = 1'b0;
      while (bus_ack) begin
         @(posedge clk_x);
         #2;
      end
   endtask

   task automatic read_all();
      int lat;
      for (int k = 0; k < `CORR_SLOTS; k++)
         bus_read(k, lat);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors == errs_before)
         $display("test %-12s ok", name);
      else
         $display("test %-12s FAIL, %0d errors", name, errors - errs_before);
   endtask

   // ----------------------------------------------------------------------
   // Readout compare, at the falling edge where bus_data is settled
   // ----------------------------------------------------------------------
   always @(negedge clk_x) begin
      vis_t e;
      int   a;
      if (bus_ack && !ack_prev) begin
         if (exp_q.size() == 0) begin
            $display("Readout returned data with no request pending");
            errors++;
         end else begin
            e = exp_q.pop_front();
            a = addr_q.pop_front();
            checks++;
            if (bus_data !== e) begin
               $display("[ERROR] %0t: slot %0d cos/sin %0d/%0d, expected %0d/%0d",
                        $time, a, bus_data.cos, bus_data.sin, e.cos, e.sin);
               errors++;
            end
         end
      end
      ack_prev = bus_ack;
   end

   // Hard stop in case a handshake stalls
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, run still going after %0d ns", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      int lat;
      int e0;
      rst      = 1'b1;
      samp_req = 1'b0;
      samp_re  = '0;
      samp_im  = '0;
      swap_req = 1'b0;
      bus_req  = 1'b0;
      bus_addr = '0;
      seed     = 31237;
      errors   = 0;
      checks   = 0;
      ack_prev = 1'b0;
      exp_bank = 1'b0;
      for (int k = 0; k < `CORR_SLOTS; k++) begin
         exp_vis[0][k] = '0;
         exp_vis[1][k] = '0;
         exp_clr[k]    = 1'b1;
      end

      repeat (3) @(posedge clk_x);
      #2;
      rst = 1'b0;

      // Reset state, then a swap exposes the untouched bank
      e0 = errors;
      checks++;
      if (samp_ack || swap_ack || bus_ack) begin
         $display("[ERROR] %0t: an ack is high right after reset", $time);
         errors++;
      end
      do_swap();
      read_all();
      finish_test("reset_state", e0);

      e0 = errors;
      random_sample(lat);
      do_swap();
      read_all();
      finish_test("single", e0);

      e0 = errors;
      for (int i = 0; i < BATCH1; i++)
         random_sample(lat);
      do_swap();
      read_all();
      finish_test("many", e0);

      // Readout holds the second batch only
      e0 = errors;
      for (int i = 0; i < BATCH2; i++)
         random_sample(lat);
      do_swap();
      read_all();
      finish_test("clear_swap", e0);

      e0 = errors;
      random_sample(lat);
      checks++;
      if (lat != SAMP_LAT) begin
         $display("[ERROR] %0t: samp_ack after %0d cycles, expected %0d",
                  $time, lat, SAMP_LAT);
         errors++;
      end
      finish_test("samp_lat", e0);

      e0 = errors;
      bus_read(5, lat);
      checks++;
      if (lat != RD_LAT) begin
         $display("[ERROR] %0t: bus_ack after %0d cycles, expected %0d",
                  $time, lat, RD_LAT);
         errors++;
      end
      finish_test("rd_lat", e0);

      $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+design
design/corr_pkg.sv
design/corr_sequencer.sv
design/corr_pair_select.sv
design/corr_accumulate.sv
design/corr_accum_ram.sv
design/corr_readout.sv
design/corr_block_top.sv
testbench/corr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

# Build the correlator testbench
verilator --binary --timing --assert -Wno-fatal \
   --top-module corr_tb -f verilog.f -o corr_sim

# Result comes from the printed verdict, not the exit code
out="$(./obj_dir/corr_sim 2>&1)" || true
printf '%s\n' "$out"

if grep -qx "Testbench passed" <<< "$out"; then
   exit 0
fi
exit 1
